/* build.f */
uart_pkg.sv
apb_uart_regs.sv
uart_fifo.sv
uart_tx.sv
uart_rx.sv
apb_uart.sv
tb_apb_uart.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
    --top-module tb_apb_uart -Mdir obj_dir -f build.f

if ./obj_dir/Vtb_apb_uart | tee /dev/stderr | grep -x 'Result: PASSED' > /dev/null; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

/* tb_apb_uart.sv */
// Testbench for the APB UART with APB tasks, a serial line driver, LFSR stimulus and checks.
`timescale 1ns/10ps

module tb_apb_uart;

    localparam int NUM_BYTES   = 8;
    localparam int LOOP_DIV    = 8;
    localparam int BIG_DIV     = 1000;
    localparam int FRAMES      = 2 * NUM_BYTES + 2 + 6;
    localparam int CYCLE_LIMIT = FRAMES * 11 * LOOP_DIV + 3000;
    localparam int POLL_LIMIT  = (11 * LOOP_DIV + 40) / 3;

    logic                clk_i;
    logic                arst_n_i;
    logic                psel_i;
    logic                penable_i;
    logic                pwrite_i;
    uart_pkg::apb_addr_t paddr_i;
    uart_pkg::apb_data_t pwdata_i;
    uart_pkg::apb_data_t prdata_o;
    logic                pready_o;
    logic                pslverr_o;
    logic                uart_rx_i;
    logic                uart_tx_o;

    logic        loopback;
    logic        drv_line;
    logic [31:0] lfsr;
    int          errors;
    int          checks;
    int          cycle_count;

    // The receiver listens either to the transmitter or to the line driver.
    assign uart_rx_i = loopback ? uart_tx_o : drv_line;

    apb_uart #(
        .FIFO_DEPTH(4)
    ) i_dut (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .psel_i   (psel_i),
        .penable_i(penable_i),
        .pwrite_i (pwrite_i),
        .paddr_i  (paddr_i),
        .pwdata_i (pwdata_i),
        .prdata_o (prdata_o),
        .pready_o (pready_o),
        .pslverr_o(pslverr_o),
        .uart_rx_i(uart_rx_i),
        .uart_tx_o(uart_tx_o)
    );

    always #5 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Result: FAILED");
            $finish;
        end
    end

    a_pready_high: assert property (@(posedge clk_i) disable iff (!arst_n_i) pready_o)
    else begin
        errors++;
        $display("ERROR pready_o: got 0x%0h, expected 0x1", pready_o);
    end

    // Read data is only driven during an access cycle.
    a_prdata_idle: assert property (
        @(posedge clk_i) disable iff (!arst_n_i) !(psel_i && penable_i) |-> prdata_o == '0
    ) else begin
        errors++;
        $display("ERROR prdata_o: got 0x%08h, expected 0x00000000", prdata_o);
    end

    a_line_idle_in_reset: assert property (@(posedge clk_i) !arst_n_i |-> uart_tx_o)
    else begin
        errors++;
        $display("ERROR uart_tx_o: got 0x%0h, expected 0x1", uart_tx_o);
    end

    // Fibonacci LFSR with taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_byte(output uart_pkg::data_t b);
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsr_next(lfsr);
            b[i] = lfsr[0];
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERROR %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic apb_write(input uart_pkg::apb_addr_t addr, input uart_pkg::apb_data_t data,
                             output logic err);
        @(negedge clk_i);
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = 1'b1;
        paddr_i   = addr;
        pwdata_i  = data;
        @(negedge clk_i);
        penable_i = 1'b1;
        #1;
        err = pslverr_o;
        @(negedge clk_i);
        psel_i    = 1'b0;
        penable_i = 1'b0;
    endtask

    task automatic apb_read(input uart_pkg::apb_addr_t addr, output uart_pkg::apb_data_t data,
                            output logic err);
        @(negedge clk_i);
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
        paddr_i   = addr;
        @(negedge clk_i);
        penable_i = 1'b1;
        #1;
        data = prdata_o;
        err  = pslverr_o;
        @(negedge clk_i);
        psel_i    = 1'b0;
        penable_i = 1'b0;
    endtask

    task automatic write_expect(input uart_pkg::apb_addr_t addr, input uart_pkg::apb_data_t data,
                                input logic exp_err);
        logic err;
        apb_write(addr, data, err);
        check_value("pslverr_o", err, exp_err);
    endtask

    task automatic read_expect(input uart_pkg::apb_addr_t addr, input uart_pkg::apb_data_t exp,
                               input logic exp_err);
        uart_pkg::apb_data_t data;
        logic                err;
        apb_read(addr, data, err);
        check_value("prdata_o", data, exp);
        check_value("pslverr_o", err, exp_err);
    endtask

    task automatic poll_status(input int bit_pos, input logic level);
        uart_pkg::apb_data_t st;
        logic                err;
        int                  polls;
        polls = 0;
        apb_read(uart_pkg::STATUS_ADDR, st, err);
        while (st[bit_pos] != level && polls < POLL_LIMIT) begin
            apb_read(uart_pkg::STATUS_ADDR, st, err);
            polls++;
        end
        checks++;
        assert (st[bit_pos] == level) else begin
            errors++;
            $display("Status bit %0d did not reach %0d within %0d polls",
                     bit_pos, level, POLL_LIMIT);
        end
    endtask

    task automatic check_status_bit(input string name, input int bit_pos, input logic exp);
        uart_pkg::apb_data_t st;
        logic                err;
        apb_read(uart_pkg::STATUS_ADDR, st, err);
        check_value(name, st[bit_pos], exp);
    endtask

    // Start bit, eight data bits LSB first, optional parity, one stop bit.
    task automatic send_frame(input uart_pkg::data_t b, input logic with_parity,
                              input logic parity_bit, input int div);
        logic [10:0] bits;
        int          nbits;
        bits  = with_parity ? {1'b1, parity_bit, b, 1'b0} : {2'b11, b, 1'b0};
        nbits = with_parity ? 11 : 10;
        @(negedge clk_i);
        for (int i = 0; i < nbits; i++) begin
            drv_line = bits[i];
            repeat (div) @(negedge clk_i);
        end
    endtask

    initial begin
        uart_pkg::data_t     sent [$];
        uart_pkg::data_t     b;
        uart_pkg::apb_data_t ctrl;
        logic                odd;
        clk_i       = 1'b0;
        arst_n_i    = 1'b0;
        psel_i      = 1'b0;
        penable_i   = 1'b0;
        pwrite_i    = 1'b0;
        paddr_i     = '0;
        pwdata_i    = '0;
        loopback    = 1'b0;
        drv_line    = 1'b1;
        lfsr        = 32'hb9ac5290;
        errors      = 0;
        checks      = 0;
        cycle_count = 0;
        repeat (16) @(negedge clk_i);
        arst_n_i = 1'b1;

        // Reset values.
        @(negedge clk_i);
        check_value("uart_tx_o", uart_tx_o, 1'b1);
        read_expect(uart_pkg::STATUS_ADDR, 32'h0000_0003, 1'b0);
        read_expect(uart_pkg::CONTROL_ADDR, 32'h0, 1'b0);
        read_expect(uart_pkg::DIVIDER_ADDR, 32'd16, 1'b0);

        // Loopback with even and then odd parity and two bytes in flight at a time.
        write_expect(uart_pkg::DIVIDER_ADDR, LOOP_DIV, 1'b0);
        loopback = 1'b1;
        for (int m = 0; m < 2; m++) begin
            odd  = (m == 1);
            ctrl = (32'd1 << uart_pkg::CTRL_PARITY_EN) | (32'(odd) << uart_pkg::CTRL_PARITY_ODD);
            write_expect(uart_pkg::CONTROL_ADDR, ctrl, 1'b0);
            for (int n = 0; n < NUM_BYTES / 2; n++) begin
                repeat (2) begin
                    random_byte(b);
                    sent.push_back(b);
                    write_expect(uart_pkg::TX_DATA_ADDR, 32'(b), 1'b0);
                end
                repeat (2) begin
                    poll_status(uart_pkg::ST_RX_EMPTY, 1'b0);
                    read_expect(uart_pkg::RX_DATA_ADDR, 32'(sent.pop_front()), 1'b0);
                end
            end
            check_status_bit("STATUS.parity_err", uart_pkg::ST_PARITY_ERR, 1'b0);
        end
        loopback = 1'b0;

        // Injected frame with the parity bit inverted.
        write_expect(uart_pkg::CONTROL_ADDR, 32'd1 << uart_pkg::CTRL_PARITY_EN, 1'b0);
        random_byte(b);
        send_frame(b, 1'b1, ~(^b), LOOP_DIV);
        poll_status(uart_pkg::ST_RX_EMPTY, 1'b0);
        read_expect(uart_pkg::RX_DATA_ADDR, 32'(b), 1'b0);
        check_status_bit("STATUS.parity_err", uart_pkg::ST_PARITY_ERR, 1'b1);
        // A second frame with good parity leaves a byte for the flush to drop.
        random_byte(b);
        send_frame(b, 1'b1, ^b, LOOP_DIV);
        poll_status(uart_pkg::ST_RX_EMPTY, 1'b0);
        ctrl = (32'd1 << uart_pkg::CTRL_PARITY_EN) | (32'd1 << uart_pkg::CTRL_RX_FLUSH);
        write_expect(uart_pkg::CONTROL_ADDR, ctrl, 1'b0);
        check_status_bit("STATUS.parity_err", uart_pkg::ST_PARITY_ERR, 1'b0);
        check_status_bit("STATUS.rx_empty", uart_pkg::ST_RX_EMPTY, 1'b1);

        // A slow serializer lets the TX path fill after five writes.
        write_expect(uart_pkg::CONTROL_ADDR, 32'h0, 1'b0);
        write_expect(uart_pkg::DIVIDER_ADDR, BIG_DIV, 1'b0);
        repeat (5) begin
            random_byte(b);
            write_expect(uart_pkg::TX_DATA_ADDR, 32'(b), 1'b0);
        end
        write_expect(uart_pkg::TX_DATA_ADDR, 32'h5a, 1'b1);
        check_status_bit("STATUS.tx_full", uart_pkg::ST_TX_FULL, 1'b1);
        write_expect(uart_pkg::CONTROL_ADDR, 32'd1 << uart_pkg::CTRL_TX_FLUSH, 1'b0);
        check_status_bit("STATUS.tx_full", uart_pkg::ST_TX_FULL, 1'b0);
        check_status_bit("STATUS.tx_empty", uart_pkg::ST_TX_EMPTY, 1'b1);

        // Six frames into a four entry RX FIFO.
        write_expect(uart_pkg::DIVIDER_ADDR, LOOP_DIV, 1'b0);
        repeat (6) begin
            random_byte(b);
            sent.push_back(b);
            send_frame(b, 1'b0, 1'b0, LOOP_DIV);
        end
        poll_status(uart_pkg::ST_OVERRUN, 1'b1);
        check_status_bit("STATUS.rx_full", uart_pkg::ST_RX_FULL, 1'b1);
        repeat (4) begin
            read_expect(uart_pkg::RX_DATA_ADDR, 32'(sent.pop_front()), 1'b0);
        end
        read_expect(uart_pkg::RX_DATA_ADDR, 32'h0, 1'b1);

        repeat (4) @(negedge clk_i);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* apb_uart.sv */
// APB UART top level: register block, TX and RX FIFOs, serializer and deserializer.
`timescale 1ns/10ps

module apb_uart #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  logic                psel_i,
    input  logic                penable_i,
    input  logic                pwrite_i,
    input  uart_pkg::apb_addr_t paddr_i,
    input  uart_pkg::apb_data_t pwdata_i,
    output uart_pkg::apb_data_t prdata_o,
    output logic                pready_o,
    output logic                pslverr_o,
    input  logic                uart_rx_i,
    output logic                uart_tx_o
);

    logic               tx_push_valid;
    logic               tx_push_ready;
    uart_pkg::data_t    tx_push_data;
    logic               tx_byte_valid;
    logic               tx_byte_ready;
    uart_pkg::data_t    tx_byte_data;
    logic               rx_byte_valid;
    logic               rx_byte_ready;
    uart_pkg::data_t    rx_byte_data;
    logic               rx_pop_valid;
    logic               rx_pop_ready;
    uart_pkg::data_t    rx_pop_data;
    logic               tx_flush;
    logic               rx_flush;
    logic               parity_en;
    logic               parity_odd;
    logic               parity_err;
    logic               overrun;
    uart_pkg::divider_t divider;

    apb_uart_regs i_regs (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .psel_i         (psel_i),
        .penable_i      (penable_i),
        .pwrite_i       (pwrite_i),
        .paddr_i        (paddr_i),
        .pwdata_i       (pwdata_i),
        .prdata_o       (prdata_o),
        .pready_o       (pready_o),
        .pslverr_o      (pslverr_o),
        .tx_push_ready_i(tx_push_ready),
        .tx_empty_i     (tx_byte_valid),
        .rx_pop_valid_i (rx_pop_valid),
        .rx_pop_data_i  (rx_pop_data),
        .rx_full_i      (rx_byte_ready),
        .parity_err_i   (parity_err),
        .overrun_i      (overrun),
        .tx_push_valid_o(tx_push_valid),
        .tx_push_data_o (tx_push_data),
        .rx_pop_ready_o (rx_pop_ready),
        .tx_flush_o     (tx_flush),
        .rx_flush_o     (rx_flush),
        .parity_en_o    (parity_en),
        .parity_odd_o   (parity_odd),
        .divider_o      (divider)
    );

    uart_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) i_tx_fifo (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .flush_i  (tx_flush),
        .s_valid_i(tx_push_valid),
        .s_data_i (tx_push_data),
        .s_ready_o(tx_push_ready),
        .m_valid_o(tx_byte_valid),
        .m_data_o (tx_byte_data),
        .m_ready_i(tx_byte_ready)
    );

    uart_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) i_rx_fifo (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .flush_i  (rx_flush),
        .s_valid_i(rx_byte_valid),
        .s_data_i (rx_byte_data),
        .s_ready_o(rx_byte_ready),
        .m_valid_o(rx_pop_valid),
        .m_data_o (rx_pop_data),
        .m_ready_i(rx_pop_ready)
    );

    uart_tx i_uart_tx (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .divider_i   (divider),
        .parity_en_i (parity_en),
        .parity_odd_i(parity_odd),
        .s_valid_i   (tx_byte_valid),
        .s_data_i    (tx_byte_data),
        .s_ready_o   (tx_byte_ready),
        .uart_tx_o   (uart_tx_o)
    );

    uart_rx i_uart_rx (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .divider_i   (divider),
        .parity_en_i (parity_en),
        .parity_odd_i(parity_odd),
        .uart_rx_i   (uart_rx_i),
        .m_valid_o   (rx_byte_valid),
        .m_data_o    (rx_byte_data),
        .m_ready_i   (rx_byte_ready),
        .parity_err_o(parity_err),
        .overrun_o   (overrun)
    );

endmodule

/* uart_rx.sv */
// UART frame deserializer with mid-bit sampling, parity check and overrun flag.
`timescale 1ns/10ps

module uart_rx (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  uart_pkg::divider_t divider_i,
    input  logic               parity_en_i,
    input  logic               parity_odd_i,
    input  logic               uart_rx_i,
    output logic               m_valid_o,
    output uart_pkg::data_t    m_data_o,
    input  logic               m_ready_i,
    output logic               parity_err_o,
    output logic               overrun_o
);

    uart_pkg::rx_state_t state_q;
    uart_pkg::divider_t  cnt_q;
    uart_pkg::data_t     shift_q;
    logic [2:0]          rx_sync_q;
    logic [2:0]          bit_idx_q;
    logic                par_bad_q;
    logic                rx_bit;
    logic                fall;
    logic                sample;

    // The third flop after the two synchronizer stages only serves edge detection.
    assign rx_bit = rx_sync_q[1];
    assign fall   = rx_sync_q[2] & ~rx_sync_q[1];

    // The start bit is checked at half a period and all later bits one period on.
    assign sample = (state_q == uart_pkg::RX_START) ? (cnt_q >= (divider_i >> 1) - 1'b1)
                                                    : (cnt_q >= divider_i - 1'b1);

    assign m_data_o     = shift_q;
    assign parity_err_o = m_valid_o & par_bad_q;
    assign overrun_o    = m_valid_o & ~m_ready_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rx_sync_q <= '1;
            state_q   <= uart_pkg::RX_IDLE;
            cnt_q     <= '0;
            bit_idx_q <= '0;
            m_valid_o <= 1'b0;
        end else begin
            rx_sync_q <= {rx_sync_q[1:0], uart_rx_i};
            m_valid_o <= 1'b0;
            cnt_q     <= (sample || state_q == uart_pkg::RX_IDLE) ? '0 : cnt_q + 1'b1;
            case (state_q)
                uart_pkg::RX_IDLE: begin
                    if (fall) begin
                        state_q <= uart_pkg::RX_START;
                    end
                end
                uart_pkg::RX_START: begin
                    if (sample) begin
                        state_q   <= rx_bit ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
                        bit_idx_q <= '0;
                    end
                end
                uart_pkg::RX_DATA: begin
                    if (sample) begin
                        bit_idx_q <= bit_idx_q + 1'b1;
                        if (bit_idx_q == 3'd7) begin
                            state_q <= parity_en_i ? uart_pkg::RX_PARITY : uart_pkg::RX_STOP;
                        end
                    end
                end
                uart_pkg::RX_PARITY: begin
                    if (sample) begin
                        state_q <= uart_pkg::RX_STOP;
                    end
                end
                default: begin
                    if (sample) begin
                        state_q   <= uart_pkg::RX_IDLE;
                        m_valid_o <= 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == uart_pkg::RX_IDLE && fall) begin
            par_bad_q <= 1'b0;
        end
        if (state_q == uart_pkg::RX_DATA && sample) begin
            shift_q <= {rx_bit, shift_q[7:1]};
        end
        if (state_q == uart_pkg::RX_PARITY && sample) begin
            par_bad_q <= rx_bit ^ (^shift_q) ^ parity_odd_i;
        end
    end

    // Each frame yields a single-cycle strobe.
    a_valid_pulse: assert property (
        @(posedge clk_i) disable iff (!arst_n_i) m_valid_o |=> !m_valid_o
    );

endmodule

/* uart_tx.sv */
// UART frame serializer fed from the TX FIFO.
`timescale 1ns/10ps

module uart_tx (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  uart_pkg::divider_t divider_i,
    input  logic               parity_en_i,
    input  logic               parity_odd_i,
    input  logic               s_valid_i,
    input  uart_pkg::data_t    s_data_i,
    output logic               s_ready_o,
    output logic               uart_tx_o
);

    uart_pkg::tx_state_t state_q;
    uart_pkg::divider_t  cnt_q;
    uart_pkg::data_t     shift_q;
    logic [2:0]          bit_idx_q;
    logic                parity_q;
    logic                bit_done;

    assign bit_done  = (cnt_q >= divider_i - 1'b1);
    assign s_ready_o = (state_q == uart_pkg::TX_IDLE);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= uart_pkg::TX_IDLE;
            cnt_q     <= '0;
            bit_idx_q <= '0;
        end else begin
            cnt_q <= (bit_done || s_ready_o) ? '0 : cnt_q + 1'b1;
            case (state_q)
                uart_pkg::TX_IDLE: begin
                    if (s_valid_i) begin
                        state_q <= uart_pkg::TX_START;
                    end
                end
                uart_pkg::TX_START: begin
                    if (bit_done) begin
                        state_q   <= uart_pkg::TX_DATA;
                        bit_idx_q <= '0;
                    end
                end
                uart_pkg::TX_DATA: begin
                    if (bit_done) begin
                        bit_idx_q <= bit_idx_q + 1'b1;
                        if (bit_idx_q == 3'd7) begin
                            state_q <= parity_en_i ? uart_pkg::TX_PARITY : uart_pkg::TX_STOP;
                        end
                    end
                end
                uart_pkg::TX_PARITY: begin
                    if (bit_done) begin
                        state_q <= uart_pkg::TX_STOP;
                    end
                end
                default: begin
                    if (bit_done) begin
                        state_q <= uart_pkg::TX_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (s_valid_i && s_ready_o) begin
            shift_q  <= s_data_i;
            parity_q <= (^s_data_i) ^ parity_odd_i;
        end else if (state_q == uart_pkg::TX_DATA && bit_done) begin
            shift_q <= shift_q >> 1;
        end
    end

    always_comb begin
        case (state_q)
            uart_pkg::TX_START:  uart_tx_o = 1'b0;
            uart_pkg::TX_DATA:   uart_tx_o = shift_q[0];
            uart_pkg::TX_PARITY: uart_tx_o = parity_q;
            default:             uart_tx_o = 1'b1;
        endcase
    end

    // An accepted byte starts its frame with the line low on the next cycle.
    a_start_low: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        (s_valid_i && s_ready_o) |=> (state_q == uart_pkg::TX_START) && !uart_tx_o
    );

endmodule

/* uart_fifo.sv */
// Synchronous byte FIFO with valid/ready on both sides and a flush input.
`timescale 1ns/10ps

module uart_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic            clk_i,
    input  logic            arst_n_i,
    input  logic            flush_i,
    input  logic            s_valid_i,
    input  uart_pkg::data_t s_data_i,
    output logic            s_ready_o,
    output logic            m_valid_o,
    output uart_pkg::data_t m_data_o,
    input  logic            m_ready_i
);

    localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CW = AW + 1;

    uart_pkg::data_t mem [FIFO_DEPTH];
    logic [AW-1:0]   wr_ptr_q;
    logic [AW-1:0]   rd_ptr_q;
    logic [CW-1:0]   count_q;
    logic            push;
    logic            pop;

    assign s_ready_o = (count_q != CW'(FIFO_DEPTH));
    assign m_valid_o = (count_q != '0);
    assign m_data_o  = mem[rd_ptr_q];
    assign push      = s_valid_i & s_ready_o;
    assign pop       = m_valid_o & m_ready_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push && !flush_i) begin
            mem[wr_ptr_q] <= s_data_i;
        end
    end

    a_count_bound: assert property (
        @(posedge clk_i) disable iff (!arst_n_i) count_q <= CW'(FIFO_DEPTH)
    );

endmodule

/* apb_uart_regs.sv */
// APB register block: TX push, RX pop, status word, control and divider registers.
`timescale 1ns/10ps

module apb_uart_regs (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  logic                psel_i,
    input  logic                penable_i,
    input  logic                pwrite_i,
    input  uart_pkg::apb_addr_t paddr_i,
    input  uart_pkg::apb_data_t pwdata_i,
    output uart_pkg::apb_data_t prdata_o,
    output logic                pready_o,
    output logic                pslverr_o,
    input  logic                tx_push_ready_i,
    input  logic                tx_empty_i,
    input  logic                rx_pop_valid_i,
    input  uart_pkg::data_t     rx_pop_data_i,
    input  logic                rx_full_i,
    input  logic                parity_err_i,
    input  logic                overrun_i,
    output logic                tx_push_valid_o,
    output uart_pkg::data_t     tx_push_data_o,
    output logic                rx_pop_ready_o,
    output logic                tx_flush_o,
    output logic                rx_flush_o,
    output logic                parity_en_o,
    output logic                parity_odd_o,
    output uart_pkg::divider_t  divider_o
);

    uart_pkg::divider_t  divider_q;
    uart_pkg::apb_data_t status;
    logic                wr_access;
    logic                rd_access;
    logic                parity_err_q;
    logic                overrun_q;

    assign wr_access = psel_i & penable_i & pwrite_i;
    assign rd_access = psel_i & penable_i & ~pwrite_i;
    assign pready_o  = 1'b1;

    assign tx_push_valid_o = wr_access && (paddr_i == uart_pkg::TX_DATA_ADDR);
    assign tx_push_data_o  = pwdata_i[7:0];
    assign rx_pop_ready_o  = rd_access && (paddr_i == uart_pkg::RX_DATA_ADDR);

    // Flush strobes act on the edge that ends the control write.
    assign tx_flush_o = wr_access && (paddr_i == uart_pkg::CONTROL_ADDR)
                        && pwdata_i[uart_pkg::CTRL_TX_FLUSH];
    assign rx_flush_o = wr_access && (paddr_i == uart_pkg::CONTROL_ADDR)
                        && pwdata_i[uart_pkg::CTRL_RX_FLUSH];

    assign pslverr_o = (tx_push_valid_o & ~tx_push_ready_i)
                     | (rx_pop_ready_o & ~rx_pop_valid_i);

    // Bit periods shorter than four cycles leave no room for mid-bit sampling.
    assign divider_o = (divider_q < 16'd4) ? 16'd4 : divider_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            parity_en_o  <= 1'b0;
            parity_odd_o <= 1'b0;
            divider_q    <= uart_pkg::DIVIDER_RESET;
            parity_err_q <= 1'b0;
            overrun_q    <= 1'b0;
        end else begin
            if (wr_access && paddr_i == uart_pkg::CONTROL_ADDR) begin
                parity_en_o  <= pwdata_i[uart_pkg::CTRL_PARITY_EN];
                parity_odd_o <= pwdata_i[uart_pkg::CTRL_PARITY_ODD];
            end
            if (wr_access && paddr_i == uart_pkg::DIVIDER_ADDR) begin
                divider_q <= pwdata_i[15:0];
            end
            if (rx_flush_o) begin
                parity_err_q <= 1'b0;
                overrun_q    <= 1'b0;
            end else begin
                parity_err_q <= parity_err_q | parity_err_i;
                overrun_q    <= overrun_q | overrun_i;
            end
        end
    end

    // FIFO valid and ready come in active high, so empty and full are their inverses.
    always_comb begin
        status                          = '0;
        status[uart_pkg::ST_RX_EMPTY]   = ~rx_pop_valid_i;
        status[uart_pkg::ST_TX_EMPTY]   = ~tx_empty_i;
        status[uart_pkg::ST_RX_FULL]    = ~rx_full_i;
        status[uart_pkg::ST_TX_FULL]    = ~tx_push_ready_i;
        status[uart_pkg::ST_PARITY_ERR] = parity_err_q;
        status[uart_pkg::ST_OVERRUN]    = overrun_q;
    end

    always_comb begin
        prdata_o = '0;
        if (rd_access) begin
            case (paddr_i)
                uart_pkg::RX_DATA_ADDR: begin
                    if (rx_pop_valid_i) begin
                        prdata_o = uart_pkg::apb_data_t'(rx_pop_data_i);
                    end
                end
                uart_pkg::STATUS_ADDR:  prdata_o = status;
                uart_pkg::CONTROL_ADDR: begin
                    prdata_o[uart_pkg::CTRL_PARITY_EN]  = parity_en_o;
                    prdata_o[uart_pkg::CTRL_PARITY_ODD] = parity_odd_o;
                end
                uart_pkg::DIVIDER_ADDR: prdata_o = uart_pkg::apb_data_t'(divider_q);
                default:                prdata_o = '0;
            endcase
        end
    end

    // Penable may only rise while psel is held.
    a_penable_in_sel: assert property (
        @(posedge clk_i) disable iff (!arst_n_i) $rose(penable_i) |-> psel_i
    );

endmodule

/* uart_pkg.sv */
// UART widths, APB register map, control and status bit positions, FSM state types.
package uart_pkg;

    typedef logic [7:0]  data_t;
    typedef logic [4:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;
    typedef logic [15:0] divider_t;

    // Register offsets.
    localparam apb_addr_t TX_DATA_ADDR = 5'h00;
    localparam apb_addr_t RX_DATA_ADDR = 5'h04;
    localparam apb_addr_t STATUS_ADDR  = 5'h08;
    localparam apb_addr_t CONTROL_ADDR = 5'h0C;
    localparam apb_addr_t DIVIDER_ADDR = 5'h10;

    // Control bits. The two flush bits read back as zero.
    localparam int CTRL_TX_FLUSH   = 0;
    localparam int CTRL_RX_FLUSH   = 1;
    localparam int CTRL_PARITY_EN  = 2;
    localparam int CTRL_PARITY_ODD = 3;

    // Status bits.
    localparam int ST_RX_EMPTY   = 0;
    localparam int ST_TX_EMPTY   = 1;
    localparam int ST_RX_FULL    = 2;
    localparam int ST_TX_FULL    = 3;
    localparam int ST_PARITY_ERR = 4;
    localparam int ST_OVERRUN    = 5;

    localparam divider_t DIVIDER_RESET = 16'd16;

    typedef enum logic [2:0] {
        TX_IDLE, TX_START, TX_DATA, TX_PARITY, TX_STOP
    } tx_state_t;

    typedef enum logic [2:0] {
        RX_IDLE, RX_START, RX_DATA, RX_PARITY, RX_STOP
    } rx_state_t;

endpackage
